//--- io_consts.svh
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// width of a core data word and of the io bus
`define IO_WIDTH 16

// barrel slots in the core, slot 0 is the boot slot
`define IO_SLOTS 4

// sample ram geometry
`define SAMPLE_DEPTH 512 // words
`define SAMPLE_AW 9      // pointer bits, log2 of SAMPLE_DEPTH

// bit positions in a dev_flags write that preset the sample pointers
`define SAMPLE_SET_WR_BIT 11
`define SAMPLE_SET_RD_BIT 10

// all-ones mask loaded after any access that is not a mask preset
`define IO_MASK_ALL {`IO_WIDTH{1'b1}}

`endif

//--- io_pkg.sv
`include "io_consts.svh"

package io_pkg;

  typedef logic [`IO_WIDTH-1:0]          io_word_t;    // one bus word
  typedef logic [$clog2(`IO_SLOTS)-1:0]  slot_t;       // hardware slot number
  typedef logic [`SAMPLE_AW-1:0]         sample_ptr_t; // sample ram pointer

  // one-hot io address, each name is the bit position of its device
  typedef enum logic [3:0] {
    dev_gpio,       // r/w gpio port
    dev_dir,        // r/w gpio direction, 1 drives the pin
    dev_led,        // r/w led register
    dev_spis,       // spi packet slave, reserved
    dev_spi2,       // second spi master, reserved
    dev_spi2_rdy,
    dev_spi,        // spi master, reserved
    dev_spi_rdy,
    dev_task1,      // slot 1 task xt
    dev_task2,      // slot 2 task xt
    dev_task3,      // slot 3 task xt
    dev_sample,     // sample ram data, auto-increment
    dev_uart,       // reserved
    dev_flags,      // status on read, sample pointer presets on write
    dev_task_fetch, // task fetch on read, slot kill on write
    dev_ticks_mask  // tick counter on read, mask preset on write
  } io_dev_e;

  // request as seen by the devices, one cycle after the core
  typedef struct packed {
    logic     rd;
    logic     wr;
    slot_t    slot;
    io_word_t addr;  // one-hot, zero when idle
    io_word_t wdata;
  } io_req_t;

endpackage

//--- io_stage.sv
`timescale 1ns/100ps
`include "io_consts.svh"

module io_stage import io_pkg::*; (
  input  logic     clk,
  input  logic     resetq,
  input  logic     io_rd,
  input  logic     io_wr,
  input  io_word_t mem_addr,
  input  io_word_t dout,
  input  slot_t    io_slot,
  output io_req_t  req,
  output io_word_t iomask
);

  io_word_t mask_preset [`IO_SLOTS]; // one pending mask per slot

  logic any_access;
  logic mask_load;

  // the core presents address and data in the same cycle as the strobe,
  // devices act one cycle later on the registered copy
  always_ff @(posedge clk) begin
    req.slot  <= io_slot;
    req.wdata <= dout;
    if (!resetq) begin
      req.rd   <= 1'b0;
      req.wr   <= 1'b0;
      req.addr <= '0;
    end else begin
      req.rd   <= io_rd;
      req.wr   <= io_wr;
      req.addr <= (io_rd | io_wr) ? mem_addr : '0; // idle bus selects no device
    end
  end

  assign any_access = req.rd | req.wr;
  assign mask_load  = req.wr & req.addr[dev_ticks_mask];

  // a mask write arms the next access of the same slot,
  // every other access by that slot falls back to all ones
  always_ff @(posedge clk) begin
    if (any_access) begin
      mask_preset[req.slot] <= mask_load ? req.wdata : `IO_MASK_ALL;
    end
  end

  assign iomask = mask_preset[req.slot]; // mask of the slot on the bus now

  // no device may see a selected address on an idle cycle
  a_idle_addr_zero: assert property (
    @(posedge clk) disable iff (!resetq)
    !(req.rd | req.wr) |-> (req.addr == '0)
  );

endmodule

//--- gpio_ports.sv
`timescale 1ns/100ps

module gpio_ports import io_pkg::*; (
  input  logic     clk,
  input  io_req_t  req,
  input  io_word_t iomask,
  input  io_word_t gpio_in,
  output io_word_t gpio_out,
  output io_word_t gpio_oe,
  output io_word_t led,
  output io_word_t gpio_rd,
  output io_word_t dir_rd
);

  logic wr_gpio;
  logic wr_dir;
  logic wr_led;

  // masked write, only bits set in mask take the new value
  function automatic io_word_t merge_masked(
    input io_word_t cur,
    input io_word_t wval,
    input io_word_t mask
  );
    return (wval & mask) | (cur & ~mask);
  endfunction

  assign wr_gpio = req.wr & req.addr[dev_gpio];
  assign wr_dir  = req.wr & req.addr[dev_dir];
  assign wr_led  = req.wr & req.addr[dev_led];

  // output latch, keeps its own value in masked-off bits
  always_ff @(posedge clk) begin
    if (wr_gpio) begin
      gpio_out <= merge_masked(gpio_out, req.wdata, iomask);
    end
  end

  // direction, 1 = output; shared ports can flip single bits
  always_ff @(posedge clk) begin
    if (wr_dir) begin
      gpio_oe <= merge_masked(gpio_oe, req.wdata, iomask);
    end
  end

  // leds double as semaphores under the mask
  always_ff @(posedge clk) begin
    if (wr_led) begin
      led <= merge_masked(led, req.wdata, iomask);
    end
  end

  // pin sample, one flop in from the pads
  always_ff @(posedge clk) begin
    gpio_rd <= gpio_in;
  end

  assign dir_rd = gpio_oe; // read back direction as written

endmodule

//--- task_sched.sv
`timescale 1ns/100ps
`include "io_consts.svh"

module task_sched import io_pkg::*; (
  input  logic                 clk,
  input  logic                 resetq,
  input  io_req_t              req,
  output io_word_t             task_rd [3],
  output io_word_t             fetch_rd,
  output logic [`IO_SLOTS-1:0] kill_slot_rq
);

  logic [1:0] slot_idx;  // task index of the slot on the bus
  logic       slot_busy; // any slot other than 0
  logic       fetch_rd_hit;

  assign slot_busy    = (req.slot != '0);
  assign slot_idx     = req.slot - 2'd1; // slot 1 owns task 0
  assign fetch_rd_hit = req.rd & req.addr[dev_task_fetch] & slot_busy;

  // task_rd doubles as the task storage, slot 0 has none
  always_ff @(posedge clk) begin
    if (!resetq) begin
      // cleared so a warm reset stops every slot
      for (int i = 0; i < 3; i++) begin
        task_rd[i] <= '0;
      end
      kill_slot_rq <= '0;
    end else if (req.wr) begin
      // any slot may schedule any other slot
      if (req.addr[dev_task1]) task_rd[0] <= req.wdata;
      if (req.addr[dev_task2]) task_rd[1] <= req.wdata;
      if (req.addr[dev_task3]) task_rd[2] <= req.wdata;
      // kill pulse lasts until the next write of any kind
      kill_slot_rq <= req.addr[dev_task_fetch] ? req.wdata[`IO_SLOTS-1:0] : '0;
    end else if (fetch_rd_hit) begin
      if (task_rd[slot_idx][0]) begin
        task_rd[slot_idx] <= '0; // run-once xt, gone after one fetch
      end
    end
  end

  // valid xts are even, bit 0 only flags run-once
  always_comb begin
    fetch_rd = '0; // slot 0 spins on a zero task
    if (slot_busy) begin
      fetch_rd = {task_rd[slot_idx][`IO_WIDTH-1:1], 1'b0};
    end
  end

  // a fetched xt is always even
  a_fetch_even: assert property (
    @(posedge clk) disable iff (!resetq)
    fetch_rd[0] == 1'b0
  );

endmodule

//--- sample_buffer.sv
`timescale 1ns/100ps
`include "io_consts.svh"

module sample_buffer import io_pkg::*; (
  input  logic     clk,
  input  io_req_t  req,
  output io_word_t sample_rd
);

  io_word_t    sample_ram [`SAMPLE_DEPTH];
  sample_ptr_t wr_ptr;
  sample_ptr_t rd_ptr;
  sample_ptr_t rd_ptr_q;  // ram read address, one cycle behind rd_ptr
  sample_ptr_t preset;    // low bits of a flags write

  logic flags_wr;
  logic set_wr_ptr;
  logic set_rd_ptr;
  logic sample_wr;
  logic sample_rd_hit;

  assign flags_wr      = req.wr & req.addr[dev_flags];
  assign set_wr_ptr    = flags_wr & req.wdata[`SAMPLE_SET_WR_BIT];
  assign set_rd_ptr    = flags_wr & req.wdata[`SAMPLE_SET_RD_BIT];
  assign preset        = req.wdata[`SAMPLE_AW-1:0];
  assign sample_wr     = req.wr & req.addr[dev_sample];
  assign sample_rd_hit = req.rd & req.addr[dev_sample];

  // pointers wrap from SAMPLE_DEPTH-1 to 0 on their own
  always_ff @(posedge clk) begin
    if (set_wr_ptr) begin
      wr_ptr <= preset;
    end else if (sample_wr) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
    if (set_rd_ptr) begin
      rd_ptr <= preset;
    end else if (sample_rd_hit) begin
      rd_ptr <= rd_ptr + 1'b1; // next word for the following read
    end
  end

  // ram port, writes straight at the pointer
  always_ff @(posedge clk) begin
    if (sample_wr) begin
      sample_ram[wr_ptr] <= req.wdata;
    end
    rd_ptr_q <= rd_ptr;
  end

  // data follows the registered pointer, so a read needs two quiet cycles
  // after the previous sample access
  assign sample_rd = sample_ram[rd_ptr_q];

endmodule

//--- io_read_mux.sv
`timescale 1ns/100ps
`include "io_consts.svh"

module io_read_mux import io_pkg::*; (
  input  logic     clk,
  input  logic     resetq,
  input  io_req_t  req,
  input  io_word_t iomask,
  input  io_word_t gpio_rd,
  input  io_word_t dir_rd,
  input  io_word_t led,
  input  io_word_t task_rd [3],
  input  io_word_t fetch_rd,
  input  io_word_t sample_rd,
  output io_word_t io_din
);

  io_word_t ticks;
  io_word_t status;
  io_word_t dev_word [`IO_WIDTH]; // read value per address bit

  // wall clock, wraps freely
  always_ff @(posedge clk) begin
    if (!resetq) begin
      ticks <= '0;
    end else begin
      ticks <= ticks + 1'b1;
    end
  end

  // msb flags a non-boot slot, the rest of the old status is gone
  assign status = {(req.slot != '0), {(`IO_WIDTH-1){1'b0}}};

  always_comb begin
    dev_word                 = '{default: '0};
    dev_word[dev_gpio]       = gpio_rd;
    dev_word[dev_dir]        = dir_rd;
    dev_word[dev_led]        = led;
    dev_word[dev_spis]       = '0; // dropped devices read zero
    dev_word[dev_spi2]       = '0;
    dev_word[dev_spi2_rdy]   = '0;
    dev_word[dev_spi]        = '0;
    dev_word[dev_spi_rdy]    = '0;
    dev_word[dev_task1]      = task_rd[0];
    dev_word[dev_task2]      = task_rd[1];
    dev_word[dev_task3]      = task_rd[2];
    dev_word[dev_sample]     = sample_rd;
    dev_word[dev_uart]       = '0;
    dev_word[dev_flags]      = status;
    dev_word[dev_task_fetch] = fetch_rd;
    dev_word[dev_ticks_mask] = ticks;
  end

  // or of every selected device, cleared mask bits read as zero
  always_comb begin
    io_word_t acc;
    acc = '0;
    for (int i = 0; i < `IO_WIDTH; i++) begin
      if (req.addr[i]) acc = acc | dev_word[i];
    end
    io_din = acc & iomask;
  end

endmodule

//--- io_top.sv
`timescale 1ns/100ps
`include "io_consts.svh"

module io_top import io_pkg::*; (
  input  logic                 clk,
  input  logic                 resetq,
  input  logic                 io_rd,
  input  logic                 io_wr,
  input  io_word_t             mem_addr,  // one-hot device select
  input  io_word_t             dout,      // core write data
  input  slot_t                io_slot,
  input  io_word_t             gpio_in,
  output io_word_t             io_din,    // read data, one cycle after the request
  output logic [`IO_SLOTS-1:0] kill_slot_rq,
  output io_word_t             gpio_out,
  output io_word_t             gpio_oe,
  output io_word_t             led
);

  io_req_t  req;        // delayed request, shared by all devices
  io_word_t iomask;     // mask of the slot on the bus
  io_word_t gpio_rd;
  io_word_t dir_rd;
  io_word_t task_rd [3];
  io_word_t fetch_rd;
  io_word_t sample_rd;

  io_stage u_stage (
    .clk      (clk),
    .resetq   (resetq),
    .io_rd    (io_rd),
    .io_wr    (io_wr),
    .mem_addr (mem_addr),
    .dout     (dout),
    .io_slot  (io_slot),
    .req      (req),
    .iomask   (iomask)
  );

  gpio_ports u_gpio (
    .clk      (clk),
    .req      (req),
    .iomask   (iomask),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .led      (led),
    .gpio_rd  (gpio_rd),
    .dir_rd   (dir_rd)
  );

  task_sched u_tasks (
    .clk          (clk),
    .resetq       (resetq),
    .req          (req),
    .task_rd      (task_rd),
    .fetch_rd     (fetch_rd),
    .kill_slot_rq (kill_slot_rq)
  );

  sample_buffer u_samples (
    .clk       (clk),
    .req       (req),
    .sample_rd (sample_rd)
  );

  io_read_mux u_rdmux (
    .clk       (clk),
    .resetq    (resetq),
    .req       (req),
    .iomask    (iomask),
    .gpio_rd   (gpio_rd),
    .dir_rd    (dir_rd),
    .led       (led),
    .task_rd   (task_rd),
    .fetch_rd  (fetch_rd),
    .sample_rd (sample_rd),
    .io_din    (io_din)
  );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
  input  logic reset_rq, // holds resetq low while set
  output logic clk,
  output logic resetq
);

  logic       clk_q   = 1'b0;
  logic       rst_q   = 1'b0;
  logic [1:0] por_cnt = 2'd0; // power-on reset cycles so far

  always #5 clk_q = ~clk_q; // 10 ns period

  // resetq seen low by the DUT on the first three rising edges
  always @(posedge clk_q) begin
    if (por_cnt != 2'd2) begin
      por_cnt <= por_cnt + 2'd1;
    end else begin
      rst_q <= ~reset_rq; // later resets on request
    end
  end

  assign clk    = clk_q;
  assign resetq = rst_q;

endmodule

//--- tb_io_top.sv
`timescale 1ns/100ps
`include "io_consts.svh"

module tb_io_top import io_pkg::*; ();

  logic                 clk;
  logic                 resetq;
  logic                 reset_rq = 1'b0;
  logic                 io_rd    = 1'b0;
  logic                 io_wr    = 1'b0;
  io_word_t             mem_addr = '0;
  io_word_t             dout     = '0;
  slot_t                io_slot  = '0;
  io_word_t             gpio_in  = '0;
  io_word_t             io_din;
  logic [`IO_SLOTS-1:0] kill_slot_rq;
  io_word_t             gpio_out;
  io_word_t             gpio_oe;
  io_word_t             led;

  logic [31:0] lfsr    = 32'h506c6c15;
  int          errors  = 0;
  int          stalls  = 0; // waits that ran out of cycles
  int          cycle_n = 0; // rising edges since start
  io_word_t    scratch;

  tb_clkgen clkgen0 (
    .reset_rq (reset_rq),
    .clk      (clk),
    .resetq   (resetq)
  );

  io_top dut0 (
    .clk          (clk),
    .resetq       (resetq),
    .io_rd        (io_rd),
    .io_wr        (io_wr),
    .mem_addr     (mem_addr),
    .dout         (dout),
    .io_slot      (io_slot),
    .gpio_in      (gpio_in),
    .io_din       (io_din),
    .kill_slot_rq (kill_slot_rq),
    .gpio_out     (gpio_out),
    .gpio_oe      (gpio_oe),
    .led          (led)
  );

  always @(posedge clk) cycle_n <= cycle_n + 1;

  // galois lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  // one bus word of lfsr bits
  function automatic io_word_t rand_word();
    return io_word_t'(rand_bits(`IO_WIDTH));
  endfunction

  task automatic check_word(input string what, input io_word_t got, input io_word_t exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_kill(input logic [`IO_SLOTS-1:0] got, input logic [`IO_SLOTS-1:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: kill_slot_rq is %b, expected %b", $time, got, exp);
      errors++;
    end
  endtask

  // one access for one cycle followed by three idle cycles
  task automatic bus_access(input logic rd, input io_dev_e dev, input slot_t slot,
                            input io_word_t data, output io_word_t rdata);
    io_rd    <= rd;
    io_wr    <= ~rd;
    mem_addr <= io_word_t'(1) << int'(dev); // one-hot select
    dout     <= data;
    io_slot  <= slot;
    @(posedge clk);
    io_rd    <= 1'b0;
    io_wr    <= 1'b0;
    mem_addr <= '0;
    @(negedge clk);
    rdata = io_din; // request is in the stage now
    repeat (3) @(posedge clk);
  endtask

  task automatic io_write(input io_dev_e dev, input slot_t slot, input io_word_t data);
    io_word_t unused;
    bus_access(1'b0, dev, slot, data, unused);
  endtask

  task automatic io_read(input io_dev_e dev, input slot_t slot, output io_word_t rdata);
    bus_access(1'b1, dev, slot, '0, rdata);
  endtask

  task automatic read_check(input io_dev_e dev, input slot_t slot, input io_word_t exp,
                            input string what);
    io_word_t r;
    io_read(dev, slot, r);
    check_word(what, r, exp);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (resetq !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (resetq !== 1'b1) begin
      $display("timeout: resetq did not go high within 20 cycles");
      stalls++;
    end
    @(posedge clk);
  endtask

  task automatic gpio_led_rw();
    io_word_t v;
    v = rand_word();
    gpio_in <= v; // pins looped back
    io_write(dev_gpio, 2'd0, v);
    check_word("gpio_out", gpio_out, v);
    read_check(dev_gpio, 2'd0, v, "gpio loopback read");
    v = rand_word();
    io_write(dev_dir, 2'd0, v);
    check_word("gpio_oe", gpio_oe, v);
    read_check(dev_dir, 2'd0, v, "dir read");
    v = rand_word();
    io_write(dev_led, 2'd0, v);
    check_word("led", led, v);
    read_check(dev_led, 2'd0, v, "led read");
    v = rand_word();
    gpio_in <= v;
    read_check(dev_gpio, 2'd0, v, "gpio_in read");
  endtask

  task automatic masked_led_writes();
    io_word_t v0, v1, v2, m;
    v0 = rand_word();
    io_write(dev_led, 2'd1, v0);
    m = rand_word();
    io_write(dev_ticks_mask, 2'd1, m);
    v1 = rand_word();
    io_write(dev_led, 2'd1, v1);
    check_word("masked led", led, v0 ^ ((v0 ^ v1) & m));
    v2 = rand_word();
    io_write(dev_led, 2'd1, v2); // mask is spent so this write is full again
    check_word("unmasked led", led, v2);
    m = rand_word();
    io_write(dev_ticks_mask, 2'd2, m); // slot 2 arms its own mask
    v0 = rand_word();
    io_write(dev_led, 2'd1, v0);
    check_word("slot 1 led beside slot 2 mask", led, v0);
    v1 = rand_word();
    io_write(dev_ticks_mask, 2'd1, v1);
    read_check(dev_led, 2'd1, v0 & v1, "masked led read");
    v2 = rand_word();
    io_write(dev_led, 2'd2, v2);
    check_word("slot 2 masked led", led, v0 ^ ((v0 ^ v2) & m));
  endtask

  task automatic task_run_once();
    io_word_t v, w;
    v = rand_word() | 16'h0001; // run-once task
    io_write(dev_task2, 2'd0, v);
    read_check(dev_task2, 2'd0, v, "task2 read");
    read_check(dev_task_fetch, 2'd2, v & 16'hfffe, "run-once fetch");
    read_check(dev_task_fetch, 2'd2, 16'h0000, "fetch after run-once");
    w = rand_word() & 16'hfffe; // task that stays
    io_write(dev_task3, 2'd1, w);
    read_check(dev_task_fetch, 2'd3, w, "first fetch slot 3");
    read_check(dev_task_fetch, 2'd3, w, "second fetch slot 3");
    read_check(dev_task_fetch, 2'd0, 16'h0000, "fetch slot 0");
    io_write(dev_task1, 2'd0, rand_word());
    io_write(dev_task2, 2'd0, rand_word());
    io_write(dev_task_fetch, 2'd0, 16'h000f); // kill pending across the reset
    reset_rq <= 1'b1;
    repeat (3) @(posedge clk);
    reset_rq <= 1'b0;
    wait_reset_release();
    read_check(dev_task1, 2'd0, 16'h0000, "task1 after reset");
    read_check(dev_task2, 2'd0, 16'h0000, "task2 after reset");
    read_check(dev_task3, 2'd0, 16'h0000, "task3 after reset");
    check_kill(kill_slot_rq, '0);
  endtask

  task automatic kill_pulse();
    io_word_t v;
    v = rand_word() | 16'h0001;
    io_write(dev_task_fetch, 2'd3, v);
    check_kill(kill_slot_rq, v[`IO_SLOTS-1:0]);
    io_read(dev_flags, 2'd0, scratch); // reads leave the request alone
    check_kill(kill_slot_rq, v[`IO_SLOTS-1:0]);
    io_write(dev_led, 2'd0, rand_word());
    check_kill(kill_slot_rq, '0);
  endtask

  task automatic sample_roundtrip();
    io_word_t    q[$];
    io_word_t    w;
    io_word_t    r;
    sample_ptr_t start;
    for (int pass = 0; pass < 2; pass++) begin
      // second pass starts in the top 8 words so both pointers wrap
      if (pass == 0) start = sample_ptr_t'(rand_bits(`SAMPLE_AW));
      else start = sample_ptr_t'(`SAMPLE_DEPTH - 8) | sample_ptr_t'(rand_bits(3));
      io_write(dev_flags, 2'd0, 16'h0c00 | io_word_t'(start)); // bits 11, 10 set both
      for (int i = 0; i < 12; i++) begin
        w = rand_word();
        q.push_back(w);
        io_write(dev_sample, 2'd0, w);
      end
      for (int i = 0; i < 12; i++) begin
        io_read(dev_sample, 2'd0, r);
        check_word("sample word", r, q.pop_front());
      end
    end
  endtask

  task automatic tick_delta_status();
    int       c0, c1;
    io_word_t t0, t1, d;
    c0 = cycle_n;
    io_read(dev_ticks_mask, 2'd1, t0);
    repeat (rand_bits(4)) @(posedge clk); // random spacing
    c1 = cycle_n;
    io_read(dev_ticks_mask, 2'd1, t1);
    d = t1 - t0;
    check_word("tick delta", d, io_word_t'(c1 - c0));
    read_check(dev_flags, 2'd3, 16'h8000, "status slot 3");
    read_check(dev_flags, 2'd0, 16'h0000, "status slot 0");
    read_check(dev_flags, 2'd1, 16'h8000, "status slot 1");
  endtask

  initial begin
    wait_reset_release();
    check_kill(kill_slot_rq, '0);
    // slot masks are unknown until each slot's first access
    for (int s = 0; s < `IO_SLOTS; s++) begin
      io_read(dev_flags, slot_t'(s), scratch);
    end
    gpio_led_rw();
    masked_led_writes();
    task_run_once();
    kill_pulse();
    sample_roundtrip();
    tick_delta_status();
    $display("errors %0d, timeouts %0d", errors, stalls);
    if (errors == 0 && stalls == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
io_pkg.sv
io_stage.sv
gpio_ports.sv
task_sched.sv
sample_buffer.sv
io_read_mux.sv
io_top.sv
tb_clkgen.sv
tb_io_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_io_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
